// File: flist.f
twdl_pkg.sv
twdl_step_if.sv
twdl_step_rom.sv
twdl_ctrl.sv
twdl_phase_acc.sv
twdl_cordic.sv
twdl_gen_top.sv
tb_twdl_gen.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the twiddle generator testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_twdl_gen -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All checks passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tb_twdl_gen.sv
/* self-checking testbench for the twiddle generator, stimulus table,
   real-math model of exp(-i*2*pi*r*m/N) and framing checks */
`default_nettype none

module tb_twdl_gen;
	import twdl_pkg::*;

	localparam int CORDIC_ITER = 16;
	localparam int AMP = int'(16384.0 / 1.647);
	// peak amplitude seen at the output
	localparam real PEAK = AMP * 1.647;
	localparam real PI = 3.14159265358979;
	localparam longint FULL = 64'd1048576;
	// accumulator + cordic input stage + iterations
	localparam int LATENCY = CORDIC_ITER + 3;
	localparam int TOL = 8;
	localparam int TIMEOUT = 4000;
	localparam int DRIVE_DLY = 2;
	localparam int NUM_CASES = 6;

	typedef struct packed {
		len_e len;
		logic [N_W-1:0] rows;
		logic [N_W-1:0] cols;
		int count;
		logic restart;
	} case_t;

	// len, rows, cols, expected sample count, start again while busy
	case_t cases [NUM_CASES] = '{
		'{LEN_15, 12'd3, 12'd5, 15, 1'b0},
		'{LEN_75, 12'd5, 12'd15, 75, 1'b0},
		'{LEN_300, 12'd4, 12'd75, 300, 1'b0},
		'{LEN_1200, 12'd3, 12'd16, 48, 1'b0},
		'{LEN_1200, 12'd2, 12'd600, 1200, 1'b0},
		'{LEN_75, 12'd5, 12'd15, 75, 1'b1}
	};
	string case_name [NUM_CASES] = '{
		"n15_3x5", "n75_5x15", "n300_4x75", "n1200_3x16", "n1200_2x600", "n75_restart"
	};

	logic clk;
	logic rst_n;
	logic start;
	len_e len;
	logic [N_W-1:0] rows;
	logic [N_W-1:0] cols;
	logic busy;
	logic dout_valid;
	logic dout_sop;
	sample_t dout_real;
	sample_t dout_imag;

	// collected output stream
	sample_t q_real [$];
	sample_t q_imag [$];
	logic q_sop [$];
	int sop_total;

	twdl_gen_top u_twdl_gen_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.len        (len),
		.rows       (rows),
		.cols       (cols),
		.busy       (busy),
		.dout_valid (dout_valid),
		.dout_sop   (dout_sop),
		.dout_real  (dout_real),
		.dout_imag  (dout_imag)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// outputs sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin
		if (rst_n === 1'b1) begin
			if (dout_valid) begin
				q_real.push_back(dout_real);
				q_imag.push_back(dout_imag);
				q_sop.push_back(dout_sop);
			end
			if (dout_sop) begin
				sop_total++;
			end
		end
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
		int diff;
		diff = int'(expected) - int'(actual);
		if (diff > TOL || diff < -TOL)
			abort_run($sformatf("Error: %s expected %0d actual %0d", name, expected, actual));
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (expected != actual)
			abort_run($sformatf("Error: %s expected %0d actual %0d", name, expected, actual));
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (expected !== actual)
			abort_run($sformatf("Error: %s expected %0b actual %0b", name, expected, actual));
	endtask

	task automatic check_quiet(input string where);
		check_flag({where, " busy"}, 1'b0, busy);
		check_flag({where, " dout_valid"}, 1'b0, dout_valid);
		check_flag({where, " dout_sop"}, 1'b0, dout_sop);
	endtask

	task automatic wait_busy(input logic level, input string what);
		int cnt;
		cnt = 0;
		while (busy !== level) begin
			if (cnt >= TIMEOUT)
				abort_run({"timeout: busy never went ", level ? "high" : "low", " in ", what});
			else begin
				next_cycle();
				cnt++;
			end
		end
	endtask

	task automatic wait_samples(input int count, input string what);
		int cnt;
		cnt = 0;
		while (q_real.size() < count) begin
			if (cnt >= TIMEOUT)
				abort_run({"timeout: too few output samples arrived in ", what});
			else begin
				next_cycle();
				cnt++;
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	function automatic int n_of(input len_e l);
		case (l)
			LEN_300: return 300;
			LEN_75: return 75;
			LEN_15: return 15;
			LEN_3: return 3;
			default: return 1200;
		endcase
	endfunction

	// floor(r*m*2**20/N) wrapped to one circle
	function automatic longint model_phase(input int n, input int r, input int m);
		longint prod;
		prod = longint'(r) * longint'(m) * FULL;
		return (prod / n) % FULL;
	endfunction

	function automatic sample_t model_cos(input longint ph);
		real th;
		th = 2.0 * PI * real'(ph) / real'(FULL);
		return sample_t'(int'(PEAK * $cos(th)));
	endfunction

	function automatic sample_t model_neg_sin(input longint ph);
		real th;
		th = 2.0 * PI * real'(ph) / real'(FULL);
		return sample_t'(-int'(PEAK * $sin(th)));
	endfunction

	// ------------------------------------------------------------------------
	// one table entry
	// ------------------------------------------------------------------------
	task automatic run_case(input int idx);
		case_t tc;
		string name;
		int n;
		int r;
		int m;
		int cols_i;
		real th;
		longint ph;
		tc = cases[idx];
		name = case_name[idx];
		n = n_of(tc.len);
		cols_i = int'(tc.cols);
		q_real.delete();
		q_imag.delete();
		q_sop.delete();
		sop_total = 0;
		check_flag({name, " idle before start"}, 1'b0, busy);
		len = tc.len;
		rows = tc.rows;
		cols = tc.cols;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		wait_busy(1'b1, name);
		// second start mid-run must be dropped
		if (tc.restart) begin
			next_cycle();
			start = 1'b1;
			next_cycle();
			start = 1'b0;
		end
		wait_busy(1'b0, name);
		wait_samples(tc.count, name);
		// let any stray sample drain out of the pipeline
		repeat (LATENCY + 4) next_cycle();
		check_count({name, " sample count"}, tc.count, q_real.size());
		check_count({name, " sop count"}, int'(tc.rows), sop_total);
		for (int k = 0; k < q_real.size(); k++) begin
			r = k / cols_i;
			m = k % cols_i;
			ph = model_phase(n, r, m);
			check_flag($sformatf("%s r%0d m%0d sop", name, r, m), m == 0, q_sop[k]);
			check_sample($sformatf("%s r%0d m%0d real", name, r, m), model_cos(ph), q_real[k]);
			check_sample($sformatf("%s r%0d m%0d imag", name, r, m), model_neg_sin(ph), q_imag[k]);
		end
		// last sample against the unquantized angle, catches drift
		r = int'(tc.rows) - 1;
		m = cols_i - 1;
		th = 2.0 * PI * real'((r * m) % n) / real'(n);
		check_sample({name, " last sample exact angle real"},
			sample_t'(int'(PEAK * $cos(th))), q_real[q_real.size() - 1]);
		check_sample({name, " last sample exact angle imag"},
			sample_t'(-int'(PEAK * $sin(th))), q_imag[q_imag.size() - 1]);
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		len = LEN_1200;
		rows = '0;
		cols = '0;
		sop_total = 0;
		// first edges load the reset values
		for (int i = 0; i < 16; i++) begin
			next_cycle();
			if (i >= 2)
				check_quiet("in reset");
		end
		rst_n = 1'b1;
		for (int i = 0; i < 8; i++) begin
			next_cycle();
			check_quiet("after reset");
		end
		check_count("samples before start", 0, q_real.size());
		for (int c = 0; c < NUM_CASES; c++)
			run_case(c);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: twdl_cordic.sv
/* pipelined rotation CORDIC with quadrant fold/unfold,
   outputs cos and -sin with a matching valid/sop delay line */
`default_nettype none

module twdl_cordic #(
	parameter int CORDIC_ITER = 16,
	parameter int AMP = int'(16384.0 / 1.647)
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_sop,
	input logic [twdl_pkg::PHASE_W-1:0] phase,
	output logic out_valid,
	output logic out_sop,
	output twdl_pkg::sample_t dout_real,
	output twdl_pkg::sample_t dout_imag
);
	import twdl_pkg::*;

	// two guard bits above the output for gain overshoot
	localparam int XW = OUT_W + 2;
	// residual angle stays within +-2**18
	localparam int ZW = PHASE_W;
	localparam int LAT = CORDIC_ITER + 2;

	// atan(2**-i) in phase units, 2**20 per circle
	// table is long enough for up to 20 iterations
	localparam int ATAN_TAB [0:19] = '{
		131072, 77376, 40884, 20753, 10417, 5213, 2607, 1304,
		652, 326, 163, 81, 41, 20, 10, 5,
		3, 1, 1, 0
	};

	logic signed [XW-1:0] x [0:CORDIC_ITER];
	logic signed [XW-1:0] y [0:CORDIC_ITER];
	logic signed [ZW-1:0] z [0:CORDIC_ITER-1];
	logic [1:0] quad [0:CORDIC_ITER];
	logic signed [XW-1:0] cos_v;
	logic signed [XW-1:0] sin_v;
	logic [LAT-1:0] vld_sr;
	logic [LAT-1:0] sop_sr;

	// -------------------------------------------------------------------------
	// fold and rotation stages
	// -------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		// top two bits pick the quadrant, the rest is in [0, pi/2)
		x[0] <= XW'(AMP);
		y[0] <= '0;
		z[0] <= {2'b00, phase[PHASE_W-3:0]};
		quad[0] <= phase[PHASE_W-1 -: 2];
		for (int i = 0; i < CORDIC_ITER; i++) begin
			quad[i+1] <= quad[i];
			// drive z toward zero
			if (!z[i][ZW-1]) begin
				x[i+1] <= x[i] - (y[i] >>> i);
				y[i+1] <= y[i] + (x[i] >>> i);
			end else begin
				x[i+1] <= x[i] + (y[i] >>> i);
				y[i+1] <= y[i] - (x[i] >>> i);
			end
			// last stage has no angle to carry on
			if (i < CORDIC_ITER - 1) begin
				if (!z[i][ZW-1]) begin
					z[i+1] <= z[i] - ZW'(ATAN_TAB[i]);
				end else begin
					z[i+1] <= z[i] + ZW'(ATAN_TAB[i]);
				end
			end
		end
	end

	// unfold the quadrant
	always_comb begin
		case (quad[CORDIC_ITER])
			2'd0: begin
				cos_v = x[CORDIC_ITER];
				sin_v = y[CORDIC_ITER];
			end
			2'd1: begin
				cos_v = -y[CORDIC_ITER];
				sin_v = x[CORDIC_ITER];
			end
			2'd2: begin
				cos_v = -x[CORDIC_ITER];
				sin_v = -y[CORDIC_ITER];
			end
			default: begin
				cos_v = y[CORDIC_ITER];
				sin_v = -x[CORDIC_ITER];
			end
		endcase
	end

	// output register, imag is the negated sine
	always_ff @(posedge clk) begin
		dout_real <= cos_v[OUT_W-1:0];
		dout_imag <= sin_v[OUT_W-1:0] * -1;
	end

	// -------------------------------------------------------------------------
	// valid / sop delay line, fold + iterations + output
	// -------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_sr <= '0;
			sop_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[LAT-2:0], in_valid};
			sop_sr <= {sop_sr[LAT-2:0], in_sop};
		end
	end

	assign out_valid = vld_sr[LAT-1];
	assign out_sop = sop_sr[LAT-1];

	a_sop_valid : assert property (@(posedge clk) disable iff (!rst_n)
		out_sop |-> out_valid);

endmodule

`default_nettype wire

// File: twdl_ctrl.sv
/* row / column sequencer, drives the row and column accumulators
   and issues one phase request per cycle */
`default_nettype none

module twdl_ctrl (
	input logic clk,
	input logic rst_n,
	input logic start,
	input twdl_pkg::len_e len,
	input logic [twdl_pkg::N_W-1:0] rows,
	input logic [twdl_pkg::N_W-1:0] cols,
	input logic [twdl_pkg::N_W-1:0] n_val,
	input logic [twdl_pkg::PHASE_W-1:0] base_q,
	input logic [twdl_pkg::N_W-1:0] base_r,
	input logic [twdl_pkg::PHASE_W-1:0] row_q,
	input logic [twdl_pkg::N_W-1:0] row_r,
	twdl_step_if.src row_if,
	twdl_step_if.src col_if,
	output logic busy,
	output logic req_valid,
	output logic req_sop,
	output twdl_pkg::len_e len_q
);
	import twdl_pkg::*;

	ctrl_state_e state;
	logic [N_W-1:0] rows_q;
	logic [N_W-1:0] cols_q;
	logic [N_W-1:0] row_cnt;
	logic [N_W-1:0] col_cnt;
	logic [N_W-1:0] col_idx;
	logic last_col;
	logic last_row;

	// row acc walks r * 2**20/N
	assign row_if.step_q = base_q;
	assign row_if.step_r = base_r;
	assign row_if.modulus = n_val;

	// column acc steps by the current row step
	assign col_if.step_q = row_q;
	assign col_if.step_r = row_r;
	assign col_if.modulus = n_val;

	// column being issued this cycle, 0 in ROW
	assign col_idx = (state == COL) ? col_cnt : '0;
	assign last_col = (col_idx == cols_q - 1'b1);
	assign last_row = (row_cnt == rows_q - 1'b1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			busy <= 1'b0;
			len_q <= LEN_1200;
			rows_q <= '0;
			cols_q <= '0;
			row_cnt <= '0;
			col_cnt <= '0;
			row_if.clear <= 1'b0;
			row_if.adv <= 1'b0;
			col_if.clear <= 1'b0;
			col_if.adv <= 1'b0;
			req_valid <= 1'b0;
			req_sop <= 1'b0;
		end else begin
			// strobes are single-cycle
			row_if.clear <= 1'b0;
			row_if.adv <= 1'b0;
			col_if.clear <= 1'b0;
			col_if.adv <= 1'b0;
			req_valid <= 1'b0;
			req_sop <= 1'b0;
			case (state)
				ROW, COL: begin
					req_valid <= 1'b1;
					// column 0 restarts the phase, others add the row step
					req_sop <= (state == ROW);
					col_if.clear <= (state == ROW);
					col_if.adv <= (state == COL);
					col_cnt <= col_idx + 1'b1;
					if (!last_col) begin
						state <= COL;
					end else if (last_row) begin
						state <= IDLE;
					end else begin
						// next row step lands before its column 1
						row_if.adv <= 1'b1;
						row_cnt <= row_cnt + 1'b1;
						state <= ROW;
					end
				end
				default: begin
					// busy drops one cycle after the last request
					busy <= 1'b0;
					if (start && !busy) begin
						busy <= 1'b1;
						len_q <= len;
						rows_q <= rows;
						cols_q <= cols;
						row_cnt <= '0;
						row_if.clear <= 1'b1;
						state <= ROW;
					end
				end
			endcase
		end
	end

	// -------------------------------------------------------------------------
	// protocol checks
	// -------------------------------------------------------------------------
	// column counter never runs past the end of a row
	a_col_range : assert property (@(posedge clk) disable iff (!rst_n)
		(state == COL) |-> (col_cnt < cols_q));

	// accumulators only move inside a run
	a_idle_quiet : assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> !(row_if.adv || col_if.adv || col_if.clear));

endmodule

`default_nettype wire

// File: twdl_gen_top.sv
/* twiddle generator top: length table, sequencer,
   row and column accumulators, CORDIC */
`default_nettype none

module twdl_gen_top #(
	parameter int CORDIC_ITER = 16,
	parameter int AMP = int'(16384.0 / 1.647)
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input twdl_pkg::len_e len,
	input logic [twdl_pkg::N_W-1:0] rows,
	input logic [twdl_pkg::N_W-1:0] cols,
	output logic busy,
	output logic dout_valid,
	output logic dout_sop,
	output twdl_pkg::sample_t dout_real,
	output twdl_pkg::sample_t dout_imag
);
	import twdl_pkg::*;

	twdl_step_if row_if ();
	twdl_step_if col_if ();

	len_e len_q;
	logic [N_W-1:0] n_val;
	logic [PHASE_W-1:0] base_q;
	logic [N_W-1:0] base_r;
	logic [PHASE_W-1:0] row_q;
	logic [N_W-1:0] row_r;
	logic [PHASE_W-1:0] col_q;
	logic req_valid;
	logic req_sop;
	logic req_valid_d;
	logic req_sop_d;

	twdl_step_rom u_step_rom (
		.len    (len_q),
		.n_val  (n_val),
		.base_q (base_q),
		.base_r (base_r)
	);

	twdl_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.len       (len),
		.rows      (rows),
		.cols      (cols),
		.n_val     (n_val),
		.base_q    (base_q),
		.base_r    (base_r),
		.row_q     (row_q),
		.row_r     (row_r),
		.row_if    (row_if.src),
		.col_if    (col_if.src),
		.busy      (busy),
		.req_valid (req_valid),
		.req_sop   (req_sop),
		.len_q     (len_q)
	);

	// row step r * 2**20/N
	twdl_phase_acc u_row_acc (
		.clk   (clk),
		.rst_n (rst_n),
		.s     (row_if.acc),
		.acc_q (row_q),
		.acc_r (row_r)
	);

	// phase of column m, floor only so the remainder is left open
	twdl_phase_acc u_col_acc (
		.clk   (clk),
		.rst_n (rst_n),
		.s     (col_if.acc),
		.acc_q (col_q),
		.acc_r ()
	);

	// line the request up with the column accumulator output
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_valid_d <= 1'b0;
			req_sop_d <= 1'b0;
		end else begin
			req_valid_d <= req_valid;
			req_sop_d <= req_sop;
		end
	end

	twdl_cordic #(
		.CORDIC_ITER (CORDIC_ITER),
		.AMP         (AMP)
	) u_cordic (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (req_valid_d),
		.in_sop    (req_sop_d),
		.phase     (col_q),
		.out_valid (dout_valid),
		.out_sop   (dout_sop),
		.dout_real (dout_real),
		.dout_imag (dout_imag)
	);

endmodule

`default_nettype wire

// File: twdl_phase_acc.sv
/* exact phase accumulator, integer part plus remainder modulo N */
`default_nettype none

module twdl_phase_acc (
	input logic clk,
	input logic rst_n,
	twdl_step_if.acc s,
	output logic [twdl_pkg::PHASE_W-1:0] acc_q,
	output logic [twdl_pkg::N_W-1:0] acc_r
);
	import twdl_pkg::*;

	// one extra bit so the sum cannot wrap before the compare
	logic [N_W:0] r_sum;
	logic carry;

	assign r_sum = {1'b0, acc_r} + {1'b0, s.step_r};
	assign carry = (r_sum >= {1'b0, s.modulus});

	// integer part wraps mod 2**PHASE_W, i.e. once per circle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc_q <= '0;
			acc_r <= '0;
		end else if (s.clear) begin
			acc_q <= '0;
			acc_r <= '0;
		end else if (s.adv) begin
			acc_q <= acc_q + s.step_q + {{(PHASE_W-1){1'b0}}, carry};
			// fold remainder back below N
			if (carry) begin
				acc_r <= N_W'(r_sum - {1'b0, s.modulus});
			end else begin
				acc_r <= r_sum[N_W-1:0];
			end
		end
	end

	// each step leaves the remainder a proper residue of N
	a_rem_range : assert property (@(posedge clk) disable iff (!rst_n)
		s.adv |=> (acc_r < s.modulus));

endmodule

`default_nettype wire

// File: twdl_pkg.sv
/* shared widths, transform length enum, controller state enum
   and the output sample type for the twiddle generator */
`default_nettype none

package twdl_pkg;

	// full circle is 2**PHASE_W
	localparam int PHASE_W = 20;

	// lengths, row and column counts, remainders
	localparam int N_W = 12;

	// output sample width
	localparam int OUT_W = 16;

	// signed cosine or sine sample
	typedef logic signed [OUT_W-1:0] sample_t;

	// supported transform lengths, all divisors of 1200
	typedef enum logic [2:0] {
		LEN_1200,
		LEN_300,
		LEN_75,
		LEN_15,
		LEN_3
	} len_e;

	// row / column sequencer
	typedef enum logic [1:0] {
		IDLE,
		ROW,
		COL
	} ctrl_state_e;

endpackage

`default_nettype wire

// File: twdl_step_if.sv
/* step and control bundle from the sequencer into a phase accumulator */
`default_nettype none

interface twdl_step_if;
	import twdl_pkg::*;

	// restart at zero
	logic clear;
	// add one step
	logic adv;
	// step as integer part plus remainder over modulus
	logic [PHASE_W-1:0] step_q;
	logic [N_W-1:0] step_r;
	// transform length N
	logic [N_W-1:0] modulus;

	modport src (output clear, adv, step_q, step_r, modulus);
	modport acc (input clear, adv, step_q, step_r, modulus);

endinterface

`default_nettype wire

// File: twdl_step_rom.sv
/* length table: N and the exact split 2**20 = N*q + r per length */
`default_nettype none

module twdl_step_rom (
	input twdl_pkg::len_e len,
	output logic [twdl_pkg::N_W-1:0] n_val,
	output logic [twdl_pkg::PHASE_W-1:0] base_q,
	output logic [twdl_pkg::N_W-1:0] base_r
);
	import twdl_pkg::*;

	// quotient and remainder of 2**20 / N, precomputed
	// so the row accumulator never needs a divider
	always_comb begin
		case (len)
			LEN_300: begin
				n_val = N_W'(300);
				base_q = PHASE_W'(3495);
				base_r = N_W'(76);
			end
			LEN_75: begin
				n_val = N_W'(75);
				base_q = PHASE_W'(13981);
				base_r = N_W'(1);
			end
			LEN_15: begin
				n_val = N_W'(15);
				base_q = PHASE_W'(69905);
				base_r = N_W'(1);
			end
			LEN_3: begin
				n_val = N_W'(3);
				base_q = PHASE_W'(349525);
				base_r = N_W'(1);
			end
			// LEN_1200 and unused codes
			default: begin
				n_val = N_W'(1200);
				base_q = PHASE_W'(873);
				base_r = N_W'(976);
			end
		endcase
	end

endmodule

`default_nettype wire
